// File: design/lcdSpiPkg.sv
// transfer-level types for the LCD SPI link
// byte and word payloads, item kinds, half-period count
package lcdSpiPkg;

	typedef logic [7:0] spiByte;   // one byte on the wire
	typedef logic [15:0] spiWord;  // pixel or parameter word

	// kind of one item handed to the transmitter
	typedef enum logic [1:0] {
		cmdByte,    // 8 bits, DCX low
		dataByte,   // 8 bits, DCX high
		dataWord,   // 16 bits, DCX high
		csRelease   // raise CSX, nothing on the wire
	} spiKind;

	// counts SCK half-periods, 32 max for a word
	typedef logic [4:0] spiBitCount;

endpackage

// File: design/lcdCmdPkg.sv
// ILI9341 command codes, the power-up table and screen geometry types
package lcdCmdPkg;

	typedef logic [8:0] lcdCoord;   // 0..319 fits
	typedef logic [15:0] lcdColor;  // rgb565

	// controller commands
	localparam lcdSpiPkg::spiByte cmdSwReset  = 8'h01;
	localparam lcdSpiPkg::spiByte cmdSleepOut = 8'h11;
	localparam lcdSpiPkg::spiByte cmdColMod   = 8'h3A;  // pixel format
	localparam lcdSpiPkg::spiByte cmdMadCtl   = 8'h36;  // memory access order
	localparam lcdSpiPkg::spiByte cmdDispOn   = 8'h29;
	localparam lcdSpiPkg::spiByte cmdColAddr  = 8'h2A;
	localparam lcdSpiPkg::spiByte cmdPageAddr = 8'h2B;
	localparam lcdSpiPkg::spiByte cmdMemWrite = 8'h2C;

	localparam int initLen = 8;

	// power-up items; display on and its release are added by the sequencer
	localparam lcdSpiPkg::spiKind initKinds [0:initLen-1] = '{
		lcdSpiPkg::cmdByte, lcdSpiPkg::csRelease,
		lcdSpiPkg::cmdByte, lcdSpiPkg::csRelease,
		lcdSpiPkg::cmdByte, lcdSpiPkg::dataByte,
		lcdSpiPkg::cmdByte, lcdSpiPkg::dataByte
	};
	localparam lcdSpiPkg::spiByte initBytes [0:initLen-1] = '{
		cmdSwReset, 8'h00,
		cmdSleepOut, 8'h00,
		cmdColMod, 8'h55,   // 16 bits per pixel
		cmdMadCtl, 8'h48    // column order flip, bgr
	};

endpackage

// File: design/lcdSpiTx.sv
// SPI transmitter for the LCD controller
// byte and word transfers, chip select and data/command control
`timescale 1ns/1ps

module lcdSpiTx (
	input  logic clk,
	input  logic rstN,
	input  logic load,                 // byte transfer, or release with releaseCs
	input  logic load16,               // word transfer, always data
	input  logic releaseCs,            // qualifies load: raise CSX, send nothing
	input  logic dcxIn,                // data/command for a byte
	input  lcdSpiPkg::spiByte byteIn,
	input  lcdSpiPkg::spiWord wordIn,
	output logic busy,                 // transfer in progress
	output logic csx,                  // chip select, active low
	output logic dcx,                  // 0 command, 1 data
	output logic sdo,
	output logic sck
);
	import lcdSpiPkg::*;

	spiWord shiftReg;      // msb is on the wire
	spiBitCount halfCnt;   // sck half-periods done in this transfer
	logic wordMode;        // 32 half-periods instead of 16
	logic lastHalf;
	logic startXfer;

	assign startXfer = load16 | (load & ~releaseCs);

	// byte ends after 8 sck periods, word after 16
	assign lastHalf = wordMode ? (halfCnt == 5'd31) : (halfCnt == 5'd15);

	// chip select, dcx, sck and the transfer counter
	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			csx <= 1'b1;       // nothing selected until the first item
			dcx <= 1'b0;
			sck <= 1'b0;
			halfCnt <= '0;
			wordMode <= 1'b0;
		end else if (load && releaseCs) begin
			csx <= 1'b1;       // end of a command group, busy stays low
		end else if (startXfer) begin
			busy <= 1'b1;
			csx <= 1'b0;       // stays low until a release
			dcx <= load16 ? 1'b1 : dcxIn;
			sck <= 1'b0;
			halfCnt <= '0;
			wordMode <= load16;
		end else if (busy) begin
			sck <= ~sck;       // half the clock rate
			halfCnt <= halfCnt + 1'b1;
			if (lastHalf) begin
				busy <= 1'b0;  // sck is high here, so it also returns low
			end
		end
	end

	// shifter, loads a byte into the top half
	always_ff @(posedge clk) begin
		if (load16) begin
			shiftReg <= wordIn;
		end else if (load && !releaseCs) begin
			shiftReg <= {byteIn, 8'h00};
		end else if (busy && sck) begin
			shiftReg <= {shiftReg[14:0], 1'b0};  // next bit on the sck fall
		end
	end

	// stable across each rising sck, low when idle
	assign sdo = busy & shiftReg[15];

endmodule

// File: design/lcdSpiArbiter.sv
// fixed-priority arbiter between the init sequencer and the rectangle fill
// holds a grant for a whole command group and decodes items for the transmitter
`timescale 1ns/1ps

module lcdSpiArbiter (
	input  logic clk,
	input  logic rstN,
	input  logic initReq,
	input  logic initStb,
	input  lcdSpiPkg::spiKind initKind,
	input  lcdSpiPkg::spiByte initByte,
	input  lcdSpiPkg::spiWord initWord,
	input  logic fillReq,
	input  logic fillStb,
	input  lcdSpiPkg::spiKind fillKind,
	input  lcdSpiPkg::spiByte fillByte,
	input  lcdSpiPkg::spiWord fillWord,
	input  logic busy,
	output logic initGnt,
	output logic fillGnt,
	output logic load,
	output logic load16,
	output logic releaseCs,
	output logic dcxOut,
	output lcdSpiPkg::spiByte byteOut,
	output lcdSpiPkg::spiWord wordOut
);
	import lcdSpiPkg::*;

	typedef enum logic [1:0] {idle, initOwner, fillOwner} grantState;

	grantState state;
	spiKind ownKind;
	logic ownStb;
	logic accept;

	// re-decide only with no grant held, init wins ties
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (initReq) state <= initOwner;
					else if (fillReq) state <= fillOwner;
				end
				initOwner: if (!initReq) state <= idle;  // dropped after its release
				fillOwner: if (!fillReq) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	assign initGnt = (state == initOwner);
	assign fillGnt = (state == fillOwner);

	// owner's item to the transmitter, strobes without a grant vanish here
	always_comb begin
		if (initGnt) begin
			ownStb = initStb;
			ownKind = initKind;
			byteOut = initByte;
			wordOut = initWord;
		end else begin
			ownStb = fillStb & fillGnt;
			ownKind = fillKind;
			byteOut = fillByte;
			wordOut = fillWord;
		end
	end

	assign accept = ownStb & ~busy;  // no restart of a running transfer
	assign load = accept & (ownKind != dataWord);
	assign load16 = accept & (ownKind == dataWord);
	assign releaseCs = accept & (ownKind == csRelease);
	assign dcxOut = (ownKind != cmdByte);

endmodule

// File: design/lcdInitSeq.sv
// power-up sequencer, steps through the init table and waits after the sw reset
`timescale 1ns/1ps

module lcdInitSeq #(
	parameter int resetWaitCycles = 1200000  // 120 ms at 10 MHz
) (
	input  logic clk,
	input  logic rstN,
	input  logic gnt,
	input  logic busy,
	output logic req,
	output logic stb,
	output lcdSpiPkg::spiKind kind,
	output lcdSpiPkg::spiByte byteVal,
	output lcdSpiPkg::spiWord wordVal,
	output logic initDone
);
	import lcdSpiPkg::*;
	import lcdCmdPkg::*;

	localparam int waitBits = $clog2(resetWaitCycles + 1);

	typedef enum logic [2:0] {
		request,    // wait for the grant
		issue,      // table item strobe
		waitBusy,   // transfer running
		resetWait,  // controller recovers from the sw reset
		finalStep,  // display on, then release
		done
	} seqState;

	seqState state;
	logic [3:0] idx;                // table entry, then the two closing items
	logic [waitBits-1:0] waitCnt;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= request;
			idx <= '0;
			waitCnt <= '0;
		end else begin
			case (state)
				request: if (gnt) state <= issue;
				issue, finalStep: begin
					idx <= idx + 1'b1;
					state <= waitBusy;
				end
				waitBusy: begin
					if (!busy) begin
						if (idx == 4'd2) begin  // release after sw reset just went out
							waitCnt <= '0;
							state <= resetWait;
						end else if (idx == 4'(initLen + 2)) begin
							state <= done;
						end else if (idx >= 4'(initLen)) begin
							state <= finalStep;
						end else begin
							state <= issue;
						end
					end
				end
				resetWait: begin
					waitCnt <= waitCnt + 1'b1;
					if (waitCnt == waitBits'(resetWaitCycles - 1)) state <= issue;
				end
				done: state <= done;
				default: state <= request;
			endcase
		end
	end

	// item for the current index
	always_comb begin
		if (state != finalStep) begin
			kind = initKinds[idx[2:0]];
			byteVal = initBytes[idx[2:0]];
		end else if (idx == 4'(initLen)) begin
			kind = cmdByte;
			byteVal = cmdDispOn;
		end else begin
			kind = csRelease;
			byteVal = 8'h00;
		end
	end

	assign wordVal = '0;  // init sends bytes only
	assign stb = (state == issue) || (state == finalStep);
	assign req = (state != done);  // grant kept through the reset wait
	assign initDone = (state == done);

endmodule

// File: design/lcdRectFill.sv
// rectangle fill engine
// address window, memory write command and one colour word per pixel
`timescale 1ns/1ps

module lcdRectFill #(
	parameter int lcdWidth = 240,
	parameter int lcdHeight = 320
) (
	input  logic clk,
	input  logic rstN,
	input  logic fillStart,
	input  lcdCmdPkg::lcdCoord fillX0,
	input  lcdCmdPkg::lcdCoord fillY0,
	input  lcdCmdPkg::lcdCoord fillX1,
	input  lcdCmdPkg::lcdCoord fillY1,
	input  lcdCmdPkg::lcdColor fillColor,
	input  logic gnt,
	input  logic busy,
	output logic req,
	output logic stb,
	output lcdSpiPkg::spiKind kind,
	output lcdSpiPkg::spiByte byteVal,
	output lcdSpiPkg::spiWord wordVal,
	output logic fillBusy
);
	import lcdSpiPkg::*;
	import lcdCmdPkg::*;

	localparam int pixBits = $clog2(lcdWidth * lcdHeight + 1);
	localparam lcdCoord maxX = lcdCoord'(lcdWidth - 1);
	localparam lcdCoord maxY = lcdCoord'(lcdHeight - 1);

	// item steps over the three command groups
	localparam logic [3:0] stepColCmd = 4'd0;
	localparam logic [3:0] stepX0 = 4'd1;
	localparam logic [3:0] stepX1 = 4'd2;
	localparam logic [3:0] stepPageCmd = 4'd4;
	localparam logic [3:0] stepY0 = 4'd5;
	localparam logic [3:0] stepY1 = 4'd6;
	localparam logic [3:0] stepMemCmd = 4'd8;
	localparam logic [3:0] stepPixel = 4'd9;
	localparam logic [3:0] stepLast = 4'd10;  // final release

	typedef enum logic [1:0] {idle, request, issue, waitBusy} fillState;

	fillState state;
	logic [3:0] step;
	logic [pixBits-1:0] pixLeft;   // colour words still to send
	lcdCoord x0, x1, y0, y1;       // latched window
	lcdColor color;
	lcdCoord cx0, cx1, cy0, cy1;   // clamped to the screen
	lcdCoord nx0, nx1, ny0, ny1;   // ordered
	lcdCoord spanX, spanY;
	logic [pixBits-1:0] pixTotal;
	logic accept;

	assign accept = fillStart & (state == idle);  // starts while busy are dropped

	always_comb begin
		cx0 = (fillX0 > maxX) ? maxX : fillX0;
		cx1 = (fillX1 > maxX) ? maxX : fillX1;
		cy0 = (fillY0 > maxY) ? maxY : fillY0;
		cy1 = (fillY1 > maxY) ? maxY : fillY1;
		nx0 = (cx0 <= cx1) ? cx0 : cx1;
		nx1 = (cx0 <= cx1) ? cx1 : cx0;
		ny0 = (cy0 <= cy1) ? cy0 : cy1;
		ny1 = (cy0 <= cy1) ? cy1 : cy0;
		spanX = nx1 - nx0 + 9'd1;
		spanY = ny1 - ny0 + 9'd1;
		pixTotal = pixBits'(spanX) * pixBits'(spanY);
	end

	// window and colour
	always_ff @(posedge clk) begin
		if (accept) begin
			x0 <= nx0;
			x1 <= nx1;
			y0 <= ny0;
			y1 <= ny1;
			color <= fillColor;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= idle;
			step <= '0;
			pixLeft <= '0;
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						step <= stepColCmd;
						pixLeft <= pixTotal;
						state <= request;
					end
				end
				request: if (gnt) state <= issue;  // held off while init owns the link
				issue: state <= waitBusy;
				waitBusy: begin
					if (!busy) begin
						if (step == stepLast) begin
							state <= idle;
						end else begin
							if (step == stepPixel) pixLeft <= pixLeft - 1'b1;
							if (step != stepPixel || pixLeft == 1) step <= step + 1'b1;
							state <= issue;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// item for the current step, group releases at 3, 7 and 10
	always_comb begin
		kind = csRelease;
		byteVal = 8'h00;
		wordVal = '0;
		case (step)
			stepColCmd: begin
				kind = cmdByte;
				byteVal = cmdColAddr;
			end
			stepX0: begin
				kind = dataWord;
				wordVal = spiWord'(x0);
			end
			stepX1: begin
				kind = dataWord;
				wordVal = spiWord'(x1);
			end
			stepPageCmd: begin
				kind = cmdByte;
				byteVal = cmdPageAddr;
			end
			stepY0: begin
				kind = dataWord;
				wordVal = spiWord'(y0);
			end
			stepY1: begin
				kind = dataWord;
				wordVal = spiWord'(y1);
			end
			stepMemCmd: begin
				kind = cmdByte;
				byteVal = cmdMemWrite;
			end
			stepPixel: begin
				kind = dataWord;
				wordVal = color;
			end
			default: kind = csRelease;
		endcase
	end

	assign stb = (state == issue);
	assign req = (state != idle);   // grant held over all three groups
	assign fillBusy = (state != idle);

endmodule

// File: design/lcdTop.sv
// LCD top level, init sequencer and rectangle fill sharing one SPI transmitter
`timescale 1ns/1ps

module lcdTop #(
	parameter int lcdWidth = 240,
	parameter int lcdHeight = 320,
	parameter int resetWaitCycles = 1200000
) (
	input  logic clk,
	input  logic rstN,
	input  logic fillStart,
	input  lcdCmdPkg::lcdCoord fillX0,
	input  lcdCmdPkg::lcdCoord fillY0,
	input  lcdCmdPkg::lcdCoord fillX1,
	input  lcdCmdPkg::lcdCoord fillY1,
	input  lcdCmdPkg::lcdColor fillColor,
	output logic csx,
	output logic dcx,
	output logic sdo,
	output logic sck,
	output logic initDone,
	output logic fillBusy
);
	import lcdSpiPkg::*;

	// init client
	logic initReq, initStb, initGnt;
	spiKind initKind;
	spiByte initByte;
	spiWord initWord;

	// fill client
	logic fillReq, fillStb, fillGnt;
	spiKind fillKind;
	spiByte fillByte;
	spiWord fillWord;

	// arbiter to transmitter
	logic load, load16, releaseCs, dcxSel, busy;
	spiByte txByte;
	spiWord txWord;

	lcdInitSeq #(
		.resetWaitCycles(resetWaitCycles)
	) lcdInitSeq_i (
		.clk(clk),
		.rstN(rstN),
		.gnt(initGnt),
		.busy(busy),
		.req(initReq),
		.stb(initStb),
		.kind(initKind),
		.byteVal(initByte),
		.wordVal(initWord),
		.initDone(initDone)
	);

	lcdRectFill #(
		.lcdWidth(lcdWidth),
		.lcdHeight(lcdHeight)
	) lcdRectFill_i (
		.clk(clk),
		.rstN(rstN),
		.fillStart(fillStart),
		.fillX0(fillX0),
		.fillY0(fillY0),
		.fillX1(fillX1),
		.fillY1(fillY1),
		.fillColor(fillColor),
		.gnt(fillGnt),
		.busy(busy),
		.req(fillReq),
		.stb(fillStb),
		.kind(fillKind),
		.byteVal(fillByte),
		.wordVal(fillWord),
		.fillBusy(fillBusy)
	);

	lcdSpiArbiter lcdSpiArbiter_i (
		.clk(clk),
		.rstN(rstN),
		.initReq(initReq),
		.initStb(initStb),
		.initKind(initKind),
		.initByte(initByte),
		.initWord(initWord),
		.fillReq(fillReq),
		.fillStb(fillStb),
		.fillKind(fillKind),
		.fillByte(fillByte),
		.fillWord(fillWord),
		.busy(busy),
		.initGnt(initGnt),
		.fillGnt(fillGnt),
		.load(load),
		.load16(load16),
		.releaseCs(releaseCs),
		.dcxOut(dcxSel),
		.byteOut(txByte),
		.wordOut(txWord)
	);

	lcdSpiTx lcdSpiTx_i (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.load16(load16),
		.releaseCs(releaseCs),
		.dcxIn(dcxSel),
		.byteIn(txByte),
		.wordIn(txWord),
		.busy(busy),
		.csx(csx),
		.dcx(dcx),
		.sdo(sdo),
		.sck(sck)
	);

endmodule

// File: sim/lcdTb.sv
// testbench for lcdTop: clock, reset, LFSR stimulus, SPI slave monitor
// frame model of init and fill traffic, typed compare tasks
`timescale 1ns/1ps

module lcdTb;
	import lcdSpiPkg::*;
	import lcdCmdPkg::*;

	localparam int lcdWidth = 240;
	localparam int lcdHeight = 320;
	localparam int waitLimit = 5000;   // cycles allowed per wait loop

	logic clk;
	logic rstN;
	logic fillStart;
	lcdCoord fillX0, fillY0, fillX1, fillY1;
	lcdColor fillColor;
	logic csx, dcx, sdo, sck, initDone, fillBusy;

	// items are {dcx, byte}, frames are kept as item counts
	logic [8:0] rxItems[$];
	int rxLens[$];
	logic [8:0] expItems[$];
	int expLens[$];
	int pendLen = 0;        // items of the frame being modelled
	spiByte shiftIn;
	int bitCnt = 0;
	int frameLen = 0;

	lcdCoord expX0, expX1, expY0, expY1;   // window the model expects
	logic [31:0] lfsr;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int testsFailed = 0;
	bit stuck = 1'b0;       // set by a timed out wait, later waits return at once

	lcdTop #(
		.lcdWidth(lcdWidth),
		.lcdHeight(lcdHeight),
		.resetWaitCycles(50)   // short recovery after sw reset
	) lcdTop_i (
		.clk(clk),
		.rstN(rstN),
		.fillStart(fillStart),
		.fillX0(fillX0),
		.fillY0(fillY0),
		.fillX1(fillX1),
		.fillY1(fillY1),
		.fillColor(fillColor),
		.csx(csx),
		.dcx(dcx),
		.sdo(sdo),
		.sck(sck),
		.initDone(initDone),
		.fillBusy(fillBusy)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;   // 8 ns period

	// spi slave, msb first, dcx taken at the last bit of each byte
	always @(posedge sck) begin
		if (rstN && !csx) begin
			shiftIn = {shiftIn[6:0], sdo};
			bitCnt++;
			if (bitCnt == 8) begin
				rxItems.push_back({dcx, shiftIn});
				frameLen++;
				bitCnt = 0;
			end
		end
	end

	// a frame ends on each rise of chip select
	always @(posedge csx) begin
		if (rstN && (frameLen > 0 || bitCnt > 0)) begin
			if (bitCnt != 0) begin
				errors++;
				$display("monitor: chip select rose in the middle of a byte");
			end
			rxLens.push_back(frameLen);
			frameLen = 0;
			bitCnt = 0;
		end
	end

	// galois form of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int unsigned takeBits(int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);   // one step per bit
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	task automatic checkByte(string test, string what, spiByte exp, spiByte act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
		end
	endtask

	task automatic checkCoord(string test, string what, lcdCoord exp, lcdCoord act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERROR %s: %s expected %0d actual %0d", test, what, exp, act);
		end
	endtask

	task automatic checkLen(string test, string what, int exp, int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("ERROR %s: %s expected %0d actual %0d", test, what, exp, act);
		end
	endtask

	task automatic checkFlag(string test, string what, logic exp, logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERROR %s: %s expected %b actual %b", test, what, exp, act);
		end
	endtask

	task automatic addItem(logic isData, spiByte b);
		expItems.push_back({isData, b});
		pendLen++;
	endtask

	task automatic addWord(logic [15:0] w);
		addItem(1'b1, w[15:8]);  // high byte first
		addItem(1'b1, w[7:0]);
	endtask

	task automatic closeFrame();
		expLens.push_back(pendLen);
		pendLen = 0;
	endtask

	// sw reset, sleep out, then one group up to display on
	task automatic expectInit();
		addItem(1'b0, 8'h01);
		closeFrame();
		addItem(1'b0, 8'h11);
		closeFrame();
		addItem(1'b0, 8'h3A);
		addItem(1'b1, 8'h55);    // rgb565
		addItem(1'b0, 8'h36);
		addItem(1'b1, 8'h48);
		addItem(1'b0, 8'h29);    // no release before display on
		closeFrame();
	endtask

	function automatic lcdCoord clampCoord(int v, int limit);
		return (v > limit - 1) ? lcdCoord'(limit - 1) : lcdCoord'(v);
	endfunction

	// clamp, order, then column, page and memory write groups
	task automatic expectFill(int ax0, int ay0, int ax1, int ay1, lcdColor c);
		lcdCoord a, b;
		int pixels;
		a = clampCoord(ax0, lcdWidth);
		b = clampCoord(ax1, lcdWidth);
		expX0 = (a < b) ? a : b;
		expX1 = (a < b) ? b : a;
		a = clampCoord(ay0, lcdHeight);
		b = clampCoord(ay1, lcdHeight);
		expY0 = (a < b) ? a : b;
		expY1 = (a < b) ? b : a;
		pixels = (expX1 - expX0 + 1) * (expY1 - expY0 + 1);
		addItem(1'b0, 8'h2A);
		addWord(16'(expX0));
		addWord(16'(expX1));
		closeFrame();
		addItem(1'b0, 8'h2B);
		addWord(16'(expY0));
		addWord(16'(expY1));
		closeFrame();
		addItem(1'b0, 8'h2C);
		for (int i = 0; i < pixels; i++) addWord(c);
		closeFrame();
	endtask

	task automatic pulseFill(int ax0, int ay0, int ax1, int ay1, lcdColor c);
		@(posedge clk);
		fillX0 <= lcdCoord'(ax0);
		fillY0 <= lcdCoord'(ay0);
		fillX1 <= lcdCoord'(ax1);
		fillY1 <= lcdCoord'(ay1);
		fillColor <= c;
		fillStart <= 1'b1;
		@(posedge clk);
		fillStart <= 1'b0;   // one cycle strobe
	endtask

	function automatic logic statusLevel(int sel);
		return (sel == 0) ? initDone : fillBusy;
	endfunction

	task automatic waitStatus(string test, string what, int sel, logic level);
		int n;
		n = 0;
		while (!stuck && statusLevel(sel) !== level && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (!stuck && statusLevel(sel) !== level) begin
			errors++;
			stuck = 1'b1;
			$display("%s: %s did not go to %b within %0d cycles", test, what, level, waitLimit);
		end
	endtask

	task automatic waitFrames(string test, int count);
		int n;
		n = 0;
		while (!stuck && rxLens.size() < count && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (!stuck && rxLens.size() < count) begin
			errors++;
			stuck = 1'b1;
			$display("%s: only %0d of %0d frames arrived in time", test, rxLens.size(), count);
		end
	endtask

	// pops every modelled frame against the received ones
	task automatic compareFrames(string test);
		int el, al;
		logic [8:0] e, a;
		while (!stuck && expLens.size() > 0) begin
			waitFrames(test, 1);
			if (!stuck) begin
				el = expLens.pop_front();
				al = rxLens.pop_front();
				checkLen(test, "frame length", el, al);
				for (int i = 0; i < el; i++) begin
					e = expItems.pop_front();
					if (i < al) begin
						a = rxItems.pop_front();
						checkByte(test, "frame byte", e[7:0], a[7:0]);
						checkFlag(test, "dcx", e[8], a[8]);
					end
				end
				for (int i = el; i < al; i++) a = rxItems.pop_front();  // surplus bytes
			end
		end
	endtask

	// decodes the window from the column and page frames at the queue head
	task automatic checkWindow(string test);
		waitFrames(test, 2);
		if (!stuck) begin
			checkLen(test, "column frame length", 5, rxLens[0]);
			checkLen(test, "page frame length", 5, rxLens[1]);
		end
		if (!stuck && rxLens[0] == 5 && rxLens[1] == 5) begin
			checkCoord(test, "x0", expX0, lcdCoord'({rxItems[1][7:0], rxItems[2][7:0]}));
			checkCoord(test, "x1", expX1, lcdCoord'({rxItems[3][7:0], rxItems[4][7:0]}));
			checkCoord(test, "y0", expY0, lcdCoord'({rxItems[6][7:0], rxItems[7][7:0]}));
			checkCoord(test, "y1", expY1, lcdCoord'({rxItems[8][7:0], rxItems[9][7:0]}));
		end
	endtask

	task automatic endTest(string test, int errBefore);
		testsRun++;
		if (errors == errBefore) begin
			$display("test %s: ok", test);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", test, errors - errBefore);
		end
	endtask

	initial begin
		int e0;
		int ax0, ay0, ax1, ay1, w, h, tmp;
		lcdColor color;
		rstN = 1'b0;
		fillStart = 1'b0;
		fillX0 = '0;
		fillY0 = '0;
		fillX1 = '0;
		fillY1 = '0;
		fillColor = '0;
		lfsr = 32'he426_1f8d;

		e0 = errors;
		repeat (2) @(posedge clk);
		checkFlag("reset", "csx in reset", 1'b1, csx);
		checkFlag("reset", "sck in reset", 1'b0, sck);
		repeat (6) @(posedge clk);
		rstN <= 1'b1;            // 8 cycles of reset
		@(posedge clk);
		checkFlag("reset", "csx after reset", 1'b1, csx);
		checkFlag("reset", "sck after reset", 1'b0, sck);
		checkFlag("reset", "sdo after reset", 1'b0, sdo);
		checkFlag("reset", "dcx after reset", 1'b0, dcx);
		checkFlag("reset", "initDone after reset", 1'b0, initDone);
		checkFlag("reset", "fillBusy after reset", 1'b0, fillBusy);
		endTest("reset", e0);

		// fill strobe lands while init holds the link
		e0 = errors;
		expectInit();
		pulseFill(5, 7, 6, 8, 16'hf800);
		waitStatus("init", "initDone", 0, 1'b1);
		compareFrames("init");
		endTest("init", e0);

		e0 = errors;
		checkFlag("arbitration", "fillBusy pending through init", 1'b1, fillBusy);
		expectFill(5, 7, 6, 8, 16'hf800);
		waitStatus("arbitration", "fillBusy", 1, 1'b0);
		compareFrames("arbitration");
		checkLen("arbitration", "frames left over", 0, rxLens.size());
		endTest("arbitration", e0);

		e0 = errors;
		for (int t = 0; t < 20; t++) begin
			w = 1 + takeBits(3) % 6;
			h = 1 + takeBits(3) % 6;
			ax0 = takeBits(8) % (lcdWidth - 6);
			ay0 = takeBits(9) % (lcdHeight - 6);
			ax1 = ax0 + w - 1;
			ay1 = ay0 + h - 1;
			color = lcdColor'(takeBits(16));
			if (takeBits(1) == 1) begin   // corners given in reverse order
				tmp = ax0;
				ax0 = ax1;
				ax1 = tmp;
			end
			pulseFill(ax0, ay0, ax1, ay1, color);
			expectFill(ax0, ay0, ax1, ay1, color);
			waitStatus("random fills", "fillBusy", 1, 1'b1);
			waitStatus("random fills", "fillBusy", 1, 1'b0);
			compareFrames("random fills");
		end
		checkLen("random fills", "frames left over", 0, rxLens.size());
		endTest("random fills", e0);

		// off-screen and swapped corners
		e0 = errors;
		pulseFill(300, 500, 236, 318, 16'h07e0);
		expectFill(300, 500, 236, 318, 16'h07e0);
		waitStatus("clamp", "fillBusy", 1, 1'b1);
		waitStatus("clamp", "fillBusy", 1, 1'b0);
		checkWindow("clamp");
		compareFrames("clamp");
		endTest("clamp", e0);

		e0 = errors;
		pulseFill(20, 30, 22, 31, 16'h001f);
		expectFill(20, 30, 22, 31, 16'h001f);
		waitStatus("ignored start", "fillBusy", 1, 1'b1);
		pulseFill(50, 60, 55, 65, 16'hffff);   // engine busy, dropped
		waitStatus("ignored start", "fillBusy", 1, 1'b0);
		repeat (200) @(posedge clk);
		checkFlag("ignored start", "fillBusy after idle time", 1'b0, fillBusy);
		compareFrames("ignored start");
		checkLen("ignored start", "frames left over", 0, rxLens.size());
		endTest("ignored start", e0);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// overall bound on the run
	initial begin
		repeat (200000) @(posedge clk);
		$display("simulation still running after 200000 cycles");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: src.f
design/lcdSpiPkg.sv
design/lcdCmdPkg.sv
design/lcdSpiTx.sv
design/lcdSpiArbiter.sv
design/lcdInitSeq.sv
design/lcdRectFill.sv
design/lcdTop.sv
sim/lcdTb.sv

// File: run.sh
#!/bin/sh
# build and run the LCD testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module lcdTb -o simv
./obj_dir/simv > sim.log 2>&1
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	exit 1
fi
exit 0
